//--- filelist.f
+incdir+.
vid_pkg.sv
vid_regs.sv
vid_raster_counter.sv
vid_sync_fsm.sv
vid_pixel_fifo.sv
vid_top.sv
tb_clock_gen.sv
tb_vid_checker.sv
tb_vid_properties.sv
tb_vid.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the video controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_vid
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_vid)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

//--- tb_vid.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module tb_vid;
    import vid_pkg::*;

    localparam logic [1:0] K_WRITE = 2'd0;
    localparam logic [1:0] K_READ  = 2'd1;
    localparam logic [1:0] K_WAIT  = 2'd2;          // data holds the hsync edge count
    localparam logic [1:0] K_PIXEL = 2'd3;          // Random pixel write
    localparam int         EDGE_TIMEOUT = 1000;

    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  addr;
        logic [31:0] data;
        logic        err;
    } step_t;

    logic       clk;
    logic       reset_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    video_out_t video;
    logic       exp_err;
    int         errors;
    int         checks;
    step_t      steps[$];
    bit         timed_out;

    tb_clock_gen u_clk_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    vid_top u_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .video   (video)
    );

    tb_vid_checker u_chk (
        .clk     (clk),
        .reset_n (reset_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .video   (video),
        .exp_err (exp_err),
        .errors  (errors),
        .checks  (checks)
    );

    function automatic logic [31:0] pair(input logic [12:0] hi, input logic [12:0] lo);
        return {6'd0, hi, lo};
    endfunction

    task automatic add_step(input logic [1:0] kind, input logic [7:0] addr,
                            input logic [31:0] data, input logic err);
        steps.push_back('{kind: kind, addr: addr, data: data, err: err});
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] data, input logic err);
        int n;
        n = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        exp_err <= err;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        do begin
            @(posedge clk);
            n++;
        end while (!apb_rsp.pready && n < EDGE_TIMEOUT);
        if (!apb_rsp.pready) begin
            $display("Timeout: pready never came for address %h", addr);
            timed_out = 1'b1;
        end
        apb_req <= '0;
        exp_err <= 1'b0;
    endtask

    task automatic wait_hsync(input int count);
        int   seen;
        int   n;
        logic prev;
        logic found;
        seen = 0;
        prev = video.hsync;
        while (seen < count && !timed_out) begin
            n     = 0;
            found = 1'b0;
            while (!found && n < EDGE_TIMEOUT) begin
                @(posedge clk);
                n++;
                found = video.hsync && !prev;
                prev  = video.hsync;
            end
            if (found) begin
                seen++;
            end else begin
                $display("Timeout: no hsync rising edge within %0d clocks", EDGE_TIMEOUT);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        int n;
        apb_req   = '0;
        exp_err   = 1'b0;
        timed_out = 1'b0;
        void'($urandom(32'h905263c6));

        // Register readback and bad accesses
        add_step(K_WRITE, `VID_ADDR_H1, pair(13'd8, 13'd11), 1'b0);
        add_step(K_WRITE, `VID_ADDR_H2, pair(13'd9, 13'd10), 1'b0);
        add_step(K_WRITE, `VID_ADDR_V1, pair(13'd3, 13'd5), 1'b0);
        add_step(K_WRITE, `VID_ADDR_V2, pair(13'd4, 13'd5), 1'b0);
        add_step(K_READ, `VID_ADDR_H1, 32'd0, 1'b0);
        add_step(K_READ, `VID_ADDR_H2, 32'd0, 1'b0);
        add_step(K_READ, `VID_ADDR_V1, 32'd0, 1'b0);
        add_step(K_READ, `VID_ADDR_V2, 32'd0, 1'b0);
        add_step(K_READ, `VID_ADDR_CTRL, 32'd0, 1'b0);
        add_step(K_READ, 8'h04, 32'd0, 1'b1);
        add_step(K_WRITE, 8'h10, 32'h1234, 1'b1);
        add_step(K_READ, `VID_ADDR_PIXEL, 32'd0, 1'b1);
        add_step(K_READ, `VID_ADDR_STATUS, 32'd0, 1'b0);
        // Raster timing with pcnt 2
        add_step(K_WRITE, `VID_ADDR_CTRL, 32'h28, 1'b0);
        add_step(K_READ, `VID_ADDR_CTRL, 32'd0, 1'b0);
        add_step(K_WAIT, 8'd0, 32'd14, 1'b0);
        add_step(K_WRITE, `VID_ADDR_CTRL, 32'h0, 1'b0);
        // Pixel stream with pcnt 0
        for (int i = 0; i < 10; i++) add_step(K_PIXEL, `VID_ADDR_PIXEL, 32'd0, 1'b0);
        add_step(K_READ, `VID_ADDR_STATUS, 32'd0, 1'b0);
        add_step(K_WRITE, `VID_ADDR_CTRL, 32'h8, 1'b0);
        add_step(K_WAIT, 8'd0, 32'd8, 1'b0);
        add_step(K_READ, `VID_ADDR_STATUS, 32'd0, 1'b0);
        add_step(K_WRITE, `VID_ADDR_CTRL, 32'h0, 1'b0);
        // Fill, overflow, flush
        for (int i = 0; i < 16; i++) add_step(K_PIXEL, `VID_ADDR_PIXEL, 32'd0, 1'b0);
        add_step(K_READ, `VID_ADDR_STATUS, 32'd0, 1'b0);
        add_step(K_PIXEL, `VID_ADDR_PIXEL, 32'd0, 1'b1);
        add_step(K_READ, `VID_ADDR_STATUS, 32'd0, 1'b0);
        add_step(K_WRITE, `VID_ADDR_CTRL, 32'h0, 1'b0);
        add_step(K_READ, `VID_ADDR_STATUS, 32'd0, 1'b0);

        n = 0;
        while (reset_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (reset_n !== 1'b1) begin
            $display("Timeout: reset never released");
            timed_out = 1'b1;
        end

        foreach (steps[i]) begin
            if (timed_out) break;
            case (steps[i].kind)
                K_WRITE: apb_access(1'b1, steps[i].addr, steps[i].data, steps[i].err);
                K_READ:  apb_access(1'b0, steps[i].addr, 32'd0, steps[i].err);
                K_WAIT:  wait_hsync(int'(steps[i].data));
                default: apb_access(1'b1, steps[i].addr, $urandom() & 32'h00FF_FFFF,
                                    steps[i].err);
            endcase
        end
        repeat (4) @(posedge clk);

        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb_vid_checker.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module tb_vid_checker (
    input  logic                clk,
    input  logic                reset_n,
    input  vid_pkg::apb_req_t   apb_req,
    input  vid_pkg::apb_rsp_t   apb_rsp,
    input  vid_pkg::video_out_t video,
    input  logic                exp_err,
    output int                  errors,
    output int                  checks
);
    import vid_pkg::*;

    logic        en;
    logic [5:0]  pcnt;
    logic [12:0] hend;
    logic [12:0] hsize;
    logic [12:0] hs_start;
    logic [12:0] hs_end;
    logic [12:0] vend;
    logic [12:0] vsize;
    logic [12:0] vs_start;
    logic [12:0] vs_end;
    logic [5:0]  div;
    logic [12:0] h;
    logic [12:0] v;
    video_out_t  exp_vid;                            // What the outputs show now
    pixel_t      pix_q[$];
    logic        ovf;
    logic        unf;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic is_mapped(input logic [7:0] a);
        return a inside {`VID_ADDR_CTRL, `VID_ADDR_H1, `VID_ADDR_H2, `VID_ADDR_V1,
                         `VID_ADDR_V2, `VID_ADDR_PIXEL, `VID_ADDR_STATUS};
    endfunction

    function automatic logic [31:0] read_model(input logic [7:0] a);
        logic [31:0] lvl;
        lvl = pix_q.size();
        case (a)
            `VID_ADDR_CTRL:   return {22'd0, pcnt, en, 3'd0};
            `VID_ADDR_H1:     return {6'd0, hsize, hend};
            `VID_ADDR_H2:     return {6'd0, hs_start, hs_end};
            `VID_ADDR_V1:     return {6'd0, vsize, vend};
            `VID_ADDR_V2:     return {6'd0, vs_start, vs_end};
            `VID_ADDR_STATUS: return {20'd0, unf, ovf, lvl == 16, lvl == 0, 3'd0, lvl[4:0]};
            default:          return 32'd0;
        endcase
    endfunction

    always @(posedge clk or negedge reset_n) begin : model
        logic tick;
        logic line_end;
        logic acc;
        logic full_pre;
        logic err;
        if (!reset_n) begin
            {en, pcnt, hend, hsize, hs_start, hs_end} = '0;
            {vend, vsize, vs_start, vs_end, div, h, v} = '0;
            exp_vid = '{hsync: 1'b0, hblank: 1'b1, vsync: 1'b0, vblank: 1'b1, rgb: '0};
            pix_q.delete();
            ovf = 1'b0;
            unf = 1'b0;
        end else begin
            compare("hsync", 32'(video.hsync), 32'(exp_vid.hsync));
            compare("hblank", 32'(video.hblank), 32'(exp_vid.hblank));
            compare("vsync", 32'(video.vsync), 32'(exp_vid.vsync));
            compare("vblank", 32'(video.vblank), 32'(exp_vid.vblank));
            compare("rgb", 32'(video.rgb), 32'(exp_vid.rgb));

            acc      = apb_req.psel & apb_req.penable;
            full_pre = (pix_q.size() == `VID_FIFO_DEPTH);
            if (acc) begin
                err = !is_mapped(apb_req.paddr) ||
                      (apb_req.paddr == `VID_ADDR_PIXEL && (!apb_req.pwrite || full_pre));
                compare("pready", 32'(apb_rsp.pready), 32'd1);
                compare("pslverr", 32'(apb_rsp.pslverr), 32'(err));
                compare("pslverr vs table", 32'(apb_rsp.pslverr), 32'(exp_err));
                if (!apb_req.pwrite) compare("prdata", apb_rsp.prdata, read_model(apb_req.paddr));
            end else begin
                compare("pslverr idle", 32'(apb_rsp.pslverr), 32'd0);
            end

            // Outputs for the next clock from the current position
            tick     = en && (div == pcnt);
            line_end = tick && (h == hend);
            if (!en) begin
                exp_vid.hsync  = 1'b0;
                exp_vid.hblank = 1'b1;
                exp_vid.vsync  = 1'b0;
                exp_vid.vblank = 1'b1;
            end else begin
                exp_vid.hsync  = (h >= hs_start) && (h < hs_end);
                exp_vid.hblank = (h >= hsize);
                exp_vid.vsync  = (v >= vs_start) && (v < vs_end);
                exp_vid.vblank = (v >= vsize);
            end
            if (tick && h < hsize && v < vsize) begin
                if (pix_q.size() > 0) begin
                    exp_vid.rgb = pix_q.pop_front();
                end else begin
                    exp_vid.rgb = '0;
                    unf = 1'b1;
                end
            end

            if (!en) begin
                {div, h, v} = '0;
            end else begin
                div = tick ? 6'd0 : div + 6'd1;
                if (line_end) begin
                    h = '0;
                    v = (v == vend) ? 13'd0 : v + 13'd1;
                end else if (tick) begin
                    h = h + 13'd1;
                end
            end

            if (acc && apb_req.pwrite) begin
                case (apb_req.paddr)
                    `VID_ADDR_CTRL: begin
                        en   = apb_req.pwdata[3];
                        pcnt = apb_req.pwdata[9:4];
                        if (!apb_req.pwdata[3]) begin
                            pix_q.delete();          // Flush wins over a pop
                            ovf = 1'b0;
                            unf = 1'b0;
                            exp_vid.rgb = '0;
                        end
                    end
                    `VID_ADDR_H1: {hsize, hend} = apb_req.pwdata[25:0];
                    `VID_ADDR_H2: {hs_start, hs_end} = apb_req.pwdata[25:0];
                    `VID_ADDR_V1: {vsize, vend} = apb_req.pwdata[25:0];
                    `VID_ADDR_V2: {vs_start, vs_end} = apb_req.pwdata[25:0];
                    `VID_ADDR_PIXEL: begin
                        if (full_pre) ovf = 1'b1;
                        else pix_q.push_back(apb_req.pwdata[23:0]);
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- tb_vid_properties.sv
`timescale 1ns/1ps

module tb_vid_properties (
    input logic                clk,
    input logic                reset_n,
    input vid_pkg::apb_req_t   apb_req,
    input vid_pkg::apb_rsp_t   apb_rsp,
    input vid_pkg::video_out_t video
);

    assert property (@(posedge clk) disable iff (!reset_n) video.hsync |-> video.hblank)
        else $error("hsync high outside horizontal blanking");

    assert property (@(posedge clk) disable iff (!reset_n) video.vsync |-> video.vblank)
        else $error("vsync high outside vertical blanking");

    // No wait states on this slave
    assert property (@(posedge clk) disable iff (!reset_n)
                     (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
        else $error("pready low in an access phase");

    assert property (@(posedge clk) disable iff (!reset_n)
                     apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr high outside an access phase");

endmodule

bind vid_top tb_vid_properties u_props (
    .clk     (clk),
    .reset_n (reset_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .video   (video)
);

//--- vid_config.svh
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// Field widths of the timing registers
`define VID_TIMING_W    13
`define VID_PCNT_W      6

// Pixel FIFO geometry
`define VID_FIFO_DEPTH  16
`define VID_FIFO_AW     4

// APB register map, byte offsets
`define VID_ADDR_CTRL   8'h00
`define VID_ADDR_H1     8'h28
`define VID_ADDR_H2     8'h30
`define VID_ADDR_V1     8'h38
`define VID_ADDR_V2     8'h40
`define VID_ADDR_PIXEL  8'h58
`define VID_ADDR_STATUS 8'h5C

`endif

//--- vid_pixel_fifo.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_pixel_fifo (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  push,
    input  vid_pkg::pixel_t       push_data,
    input  logic                  pop,
    input  logic                  flush,
    output vid_pkg::pixel_t       rgb,
    output vid_pkg::fifo_status_t fifo_status
);
    import vid_pkg::*;

    pixel_t                mem [`VID_FIFO_DEPTH];
    logic [`VID_FIFO_AW:0] wr_ptr;                  // MSB is the wrap bit
    logic [`VID_FIFO_AW:0] rd_ptr;
    logic                  full;
    logic                  empty;
    logic                  do_push;
    logic                  do_pop;
    logic                  overflow;
    logic                  underflow;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[`VID_FIFO_AW] != rd_ptr[`VID_FIFO_AW]) &&
                     (wr_ptr[`VID_FIFO_AW-1:0] == rd_ptr[`VID_FIFO_AW-1:0]);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[`VID_FIFO_AW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else if (flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && full) overflow <= 1'b1;     // Sticky until flush
            if (pop && empty) underflow <= 1'b1;
        end
    end

    // Output stage, black when starved
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rgb <= '0;
        end else if (flush) begin
            rgb <= '0;
        end else if (pop) begin
            rgb <= empty ? '0 : mem[rd_ptr[`VID_FIFO_AW-1:0]];
        end
    end

    assign fifo_status.level     = wr_ptr - rd_ptr;
    assign fifo_status.empty     = empty;
    assign fifo_status.full      = full;
    assign fifo_status.overflow  = overflow;
    assign fifo_status.underflow = underflow;

endmodule

//--- vid_pkg.sv
`include "vid_config.svh"

package vid_pkg;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [7:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // H1/H2/V1/V2 layout, high field in 25:13
    typedef struct packed {
        logic [5:0]               pad;
        logic [`VID_TIMING_W-1:0] hi;
        logic [`VID_TIMING_W-1:0] lo;
    } timing_pair_t;

    typedef struct packed {
        logic [7:0] pad;
        pixel_t     px;
    } pixel_word_t;

    // One APB data word, seen either way
    typedef union packed {
        timing_pair_t timing;
        pixel_word_t  pixel;
    } vid_word_u;

    typedef struct packed {
        logic                     en;
        logic [`VID_PCNT_W-1:0]   pcnt;
        logic [`VID_TIMING_W-1:0] hend;
        logic [`VID_TIMING_W-1:0] hsize;
        logic [`VID_TIMING_W-1:0] hsync_start;
        logic [`VID_TIMING_W-1:0] hsync_end;
        logic [`VID_TIMING_W-1:0] vend;
        logic [`VID_TIMING_W-1:0] vsize;
        logic [`VID_TIMING_W-1:0] vsync_start;
        logic [`VID_TIMING_W-1:0] vsync_end;
    } timing_cfg_t;

    typedef struct packed {
        logic [`VID_TIMING_W-1:0] h_count;
        logic [`VID_TIMING_W-1:0] v_count;
        logic                     pixel_tick;
        logic                     line_end;
    } raster_pos_t;

    typedef struct packed {
        logic [`VID_FIFO_AW:0] level;
        logic                  empty;
        logic                  full;
        logic                  overflow;
        logic                  underflow;
    } fifo_status_t;

    typedef struct packed {
        logic   hsync;
        logic   hblank;
        logic   vsync;
        logic   vblank;
        pixel_t rgb;
    } video_out_t;

    typedef enum logic [1:0] {
        h_active,
        h_front_porch,
        h_sync,
        h_back_porch
    } h_phase_e;

endpackage

//--- vid_raster_counter.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_raster_counter (
    input  logic                 clk,
    input  logic                 reset_n,
    input  vid_pkg::timing_cfg_t cfg,
    output vid_pkg::raster_pos_t pos
);

    logic [`VID_PCNT_W-1:0]   div_cnt;
    logic [`VID_TIMING_W-1:0] h_count;
    logic [`VID_TIMING_W-1:0] v_count;
    logic                     tick;
    logic                     line_end;

    // One tick every pcnt+1 clocks
    assign tick     = cfg.en & (div_cnt >= cfg.pcnt);
    assign line_end = tick & (h_count >= cfg.hend);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
        end else if (!cfg.en || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (!cfg.en) begin
            h_count <= '0;                           // Raster restarts from the origin
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            if (v_count >= cfg.vend) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else if (tick) begin
            h_count <= h_count + 1'b1;
        end
    end

    assign pos.h_count    = h_count;
    assign pos.v_count    = v_count;
    assign pos.pixel_tick = tick;
    assign pos.line_end   = line_end;

endmodule

//--- vid_regs.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_regs (
    input  logic                  clk,
    input  logic                  reset_n,
    input  vid_pkg::apb_req_t     apb_req,
    output vid_pkg::apb_rsp_t     apb_rsp,
    input  vid_pkg::fifo_status_t fifo_status,
    output vid_pkg::timing_cfg_t  cfg,
    output logic                  push,
    output vid_pkg::pixel_t       push_data,
    output logic                  flush
);
    import vid_pkg::*;

    vid_word_u wr_word;
    vid_word_u rd_word;
    logic      access;
    logic      wr_en;
    logic      rd_en;
    logic      hit_ctrl;
    logic      hit_h1;
    logic      hit_h2;
    logic      hit_v1;
    logic      hit_v2;
    logic      hit_pixel;
    logic      hit_status;
    logic      mapped;

    assign wr_word = apb_req.pwdata;
    assign access  = apb_req.psel & apb_req.penable;   // Access phase only
    assign wr_en   = access & apb_req.pwrite;
    assign rd_en   = access & ~apb_req.pwrite;

    assign hit_ctrl   = (apb_req.paddr == `VID_ADDR_CTRL);
    assign hit_h1     = (apb_req.paddr == `VID_ADDR_H1);
    assign hit_h2     = (apb_req.paddr == `VID_ADDR_H2);
    assign hit_v1     = (apb_req.paddr == `VID_ADDR_V1);
    assign hit_v2     = (apb_req.paddr == `VID_ADDR_V2);
    assign hit_pixel  = (apb_req.paddr == `VID_ADDR_PIXEL);
    assign hit_status = (apb_req.paddr == `VID_ADDR_STATUS);
    assign mapped     = hit_ctrl | hit_h1 | hit_h2 | hit_v1 | hit_v2 | hit_pixel | hit_status;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg <= '0;
        end else if (wr_en) begin
            if (hit_ctrl) begin
                cfg.en   <= apb_req.pwdata[3];
                cfg.pcnt <= apb_req.pwdata[9:4];
            end else if (hit_h1) begin
                cfg.hsize <= wr_word.timing.hi;
                cfg.hend  <= wr_word.timing.lo;
            end else if (hit_h2) begin
                cfg.hsync_start <= wr_word.timing.hi;
                cfg.hsync_end   <= wr_word.timing.lo;
            end else if (hit_v1) begin
                cfg.vsize <= wr_word.timing.hi;
                cfg.vend  <= wr_word.timing.lo;
            end else if (hit_v2) begin
                cfg.vsync_start <= wr_word.timing.hi;
                cfg.vsync_end   <= wr_word.timing.lo;
            end
        end
    end

    // FIFO drops the pixel itself when full
    assign push      = wr_en & hit_pixel;
    assign push_data = wr_word.pixel.px;
    assign flush     = wr_en & hit_ctrl & ~apb_req.pwdata[3];

    always_comb begin
        rd_word = '0;
        if (hit_ctrl) begin
            rd_word[3]   = cfg.en;
            rd_word[9:4] = cfg.pcnt;
        end else if (hit_h1) begin
            rd_word.timing.hi = cfg.hsize;
            rd_word.timing.lo = cfg.hend;
        end else if (hit_h2) begin
            rd_word.timing.hi = cfg.hsync_start;
            rd_word.timing.lo = cfg.hsync_end;
        end else if (hit_v1) begin
            rd_word.timing.hi = cfg.vsize;
            rd_word.timing.lo = cfg.vend;
        end else if (hit_v2) begin
            rd_word.timing.hi = cfg.vsync_start;
            rd_word.timing.lo = cfg.vsync_end;
        end else if (hit_status) begin
            rd_word[4:0] = fifo_status.level;
            rd_word[8]   = fifo_status.empty;
            rd_word[9]   = fifo_status.full;
            rd_word[10]  = fifo_status.overflow;
            rd_word[11]  = fifo_status.underflow;
        end
    end

    assign apb_rsp.prdata  = rd_en ? rd_word : '0;
    assign apb_rsp.pready  = 1'b1;                      // No wait states
    assign apb_rsp.pslverr = access & (~mapped | (rd_en & hit_pixel) |
                                       (wr_en & hit_pixel & fifo_status.full));

endmodule

//--- vid_sync_fsm.sv
`timescale 1ns/1ps
`include "vid_config.svh"

module vid_sync_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  vid_pkg::timing_cfg_t cfg,
    input  vid_pkg::raster_pos_t pos,
    output logic                 pop,
    output logic                 hsync,
    output logic                 hblank,
    output logic                 vsync,
    output logic                 vblank
);
    import vid_pkg::*;

    h_phase_e                 phase;
    h_phase_e                 phase_d;
    logic [`VID_TIMING_W-1:0] h_next;
    logic                     v_visible;

    // Position the counter moves to on this tick
    assign h_next    = pos.line_end ? '0 : pos.h_count + 1'b1;
    assign v_visible = (pos.v_count < cfg.vsize);

    always_comb begin
        phase_d = phase;
        if (pos.pixel_tick) begin
            if (pos.line_end) begin
                phase_d = h_active;
            end else begin
                case (phase)
                    h_active: begin
                        if (h_next >= cfg.hsize) begin
                            // Skip an empty front porch
                            phase_d = (h_next >= cfg.hsync_start) ? h_sync : h_front_porch;
                        end
                    end
                    h_front_porch: begin
                        if (h_next >= cfg.hsync_start) begin
                            phase_d = h_sync;
                        end
                    end
                    h_sync: begin
                        if (h_next >= cfg.hsync_end) begin
                            phase_d = h_back_porch;
                        end
                    end
                    default: phase_d = phase;        // Back porch runs to line end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase <= h_active;
        end else if (!cfg.en) begin
            phase <= h_active;                       // Counters sit at 0
        end else begin
            phase <= phase_d;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hsync  <= 1'b0;
            hblank <= 1'b1;
            vsync  <= 1'b0;
            vblank <= 1'b1;
        end else if (!cfg.en) begin
            hsync  <= 1'b0;
            hblank <= 1'b1;
            vsync  <= 1'b0;
            vblank <= 1'b1;
        end else begin
            hsync  <= (phase == h_sync);
            hblank <= (phase != h_active);
            vsync  <= (pos.v_count >= cfg.vsync_start) && (pos.v_count < cfg.vsync_end);
            vblank <= ~v_visible;
        end
    end

    // FIFO loads rgb on this edge, in step with the blank flags
    assign pop = pos.pixel_tick & cfg.en & (phase == h_active) & v_visible;

endmodule

//--- vid_top.sv
`timescale 1ns/1ps

module vid_top (
    input  logic                clk,
    input  logic                reset_n,
    input  vid_pkg::apb_req_t   apb_req,
    output vid_pkg::apb_rsp_t   apb_rsp,
    output vid_pkg::video_out_t video
);
    import vid_pkg::*;

    timing_cfg_t  cfg;
    raster_pos_t  pos;
    fifo_status_t fifo_status;
    pixel_t       push_data;
    logic         push;
    logic         flush;
    logic         pop;

    vid_regs u_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .fifo_status (fifo_status),
        .cfg         (cfg),
        .push        (push),
        .push_data   (push_data),
        .flush       (flush)
    );

    vid_raster_counter u_counter (
        .clk     (clk),
        .reset_n (reset_n),
        .cfg     (cfg),
        .pos     (pos)
    );

    vid_sync_fsm u_sync (
        .clk     (clk),
        .reset_n (reset_n),
        .cfg     (cfg),
        .pos     (pos),
        .pop     (pop),
        .hsync   (video.hsync),
        .hblank  (video.hblank),
        .vsync   (video.vsync),
        .vblank  (video.vblank)
    );

    vid_pixel_fifo u_fifo (
        .clk         (clk),
        .reset_n     (reset_n),
        .push        (push),
        .push_data   (push_data),
        .pop         (pop),
        .flush       (flush),
        .rgb         (video.rgb),
        .fifo_status (fifo_status)
    );

endmodule
